/* tb/display_cases.txt */
# number mode chain, then expected display 4 3 2 1 0, all hex, active low
# mode 1 is hex; chain 1 loads the next case on the very next cycle
0000 0 0 ff ff ff ff c0
0007 0 0 ff ff ff ff f8
000a 0 0 ff ff ff f9 c0
0199 0 0 ff ff 99 c0 98
ffff 0 0 82 92 92 b0 92
3039 0 0 f9 a4 b0 99 92
03e8 0 0 ff f9 c0 c0 c0
2717 0 0 f9 c0 c0 c0 f8
0063 0 0 ff ff ff 98 98
0000 1 0 ff c0 c0 c0 c0
00a5 1 0 ff c0 c0 88 92
beef 1 0 ff 83 86 86 8e
1234 1 0 ff f9 a4 b0 99
ffff 1 0 ff 8e 8e 8e 8e
0fa0 0 1 ff 99 c0 c0 c0
0fa0 1 1 ff c0 8e 88 c0
8000 0 1 b0 a4 f8 82 80
8000 1 1 ff 80 c0 c0 c0
0005 0 0 ff ff ff ff 92

/* tb.f */
src/seg_pkg.sv
src/stage_if.sv
src/display_capture.sv
src/radix_divide_stage.sv
src/digit_extract.sv
src/segment_encode.sv
src/number_display.sv
tb/tb_clock.sv
tb/display_checker.sv
tb/number_display_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the number display testbench with Verilator
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module number_display_tb \
	--Mdir "$build_dir" -o number_display_sim \
	-f tb.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$build_dir/number_display_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^RESULT: PASS$" "$log"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

/* tb/number_display_tb.sv */
`timescale 1ns/100ps

module number_display_tb;
	import seg_pkg::*;

	logic clk;
	logic rst;
	logic load;
	value_t number;
	logic hex_mode;
	seg_bank_t display;
	logic updated;
	seg_bank_t expect_bank;

	int value_errors;
	int latency_errors;
	int other_errors;
	int updates_seen;
	int loads_driven;
	int timeouts;
	int setup_errors;
	int seed;
	logic ok;

	tb_clock u_clock (
		.clk (clk),
		.rst (rst)
	);

	number_display UUT (
		.clk (clk),
		.rst (rst),
		.load (load),
		.number (number),
		.hex_mode (hex_mode),
		.display (display),
		.updated (updated)
	);

	display_checker u_check (
		.clk (clk),
		.rst (rst),
		.load (load),
		.expect_bank (expect_bank),
		.display (display),
		.updated (updated),
		.value_errors (value_errors),
		.latency_errors (latency_errors),
		.other_errors (other_errors),
		.updates_seen (updates_seen)
	);

	task automatic wait_reset_release(output logic done);
		int n;
		n = 0;
		while (rst && n < 40) begin
			@(posedge clk);
			n++;
		end
		done = !rst;
		if (!done) begin
			timeouts++;
			$display("timeout: reset was never released");
		end
	endtask

	task automatic drive_case(input value_t value, input logic mode, input seg_bank_t bank);
		@(posedge clk);
		load <= 1'b1;
		number <= value;
		hex_mode <= mode;
		expect_bank <= bank;
		loads_driven++;
	endtask

	task automatic drive_idle(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(posedge clk);
			load <= 1'b0;
		end
	endtask

	task automatic run_cases(output logic done);
		string line;
		int fd;
		int n;
		int mode;
		int chain;
		int gap;
		value_t num;
		logic [7:0] b4;
		logic [7:0] b3;
		logic [7:0] b2;
		logic [7:0] b1;
		logic [7:0] b0;
		done = 1'b1;
		fd = $fopen("tb/display_cases.txt", "r");
		if (fd == 0) begin
			setup_errors++;
			$display("could not open tb/display_cases.txt");
			done = 1'b0;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				n = $sscanf(line, "%h %h %h %h %h %h %h %h",
					num, mode, chain, b4, b3, b2, b1, b0);
				if (n == 8) begin // comment and empty lines fall through
					drive_case(num, mode != 0, {b4, b3, b2, b1, b0});
					if (chain == 0) begin
						gap = $unsigned($random(seed)) % 4;
						drive_idle(gap);
					end
				end
			end
			$fclose(fd);
			drive_idle(1);
			if (loads_driven == 0) begin
				setup_errors++;
				$display("no cases were read from tb/display_cases.txt");
				done = 1'b0;
			end
		end
	endtask

	task automatic wait_drain(output logic done);
		int n;
		n = 0;
		while (updates_seen < loads_driven && n < 100) begin
			@(negedge clk); // checker counts settle on the rising edge
			n++;
		end
		done = (updates_seen >= loads_driven);
		if (!done) begin
			timeouts++;
			$display("timeout: only %0d of %0d updates arrived", updates_seen, loads_driven);
		end
	endtask

	task automatic finish_run(input logic done);
		int total;
		total = value_errors + latency_errors + other_errors + timeouts + setup_errors;
		$display("errors: value %0d, latency %0d, other %0d, timeout %0d, setup %0d",
			value_errors, latency_errors, other_errors, timeouts, setup_errors);
		if (done && total == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	endtask

	initial begin
		load = 1'b0;
		number = '0;
		hex_mode = 1'b0;
		expect_bank = '1;
		loads_driven = 0;
		timeouts = 0;
		setup_errors = 0;
		seed = 39;
		wait_reset_release(ok);
		drive_idle(3); // blank display checked while idle
		if (ok) begin
			run_cases(ok);
		end
		if (ok) begin
			wait_drain(ok);
		end
		drive_idle(6); // last value must hold
		finish_run(ok);
	end

endmodule

/* tb/display_checker.sv */
`timescale 1ns/100ps

module display_checker (
	input logic clk,
	input logic rst,
	input logic load,
	input seg_pkg::seg_bank_t expect_bank,
	input seg_pkg::seg_bank_t display,
	input logic updated,
	output int value_errors,
	output int latency_errors,
	output int other_errors,
	output int updates_seen
);
	import seg_pkg::*;

	localparam int load_to_pulse = 7; // load edge to updated edge
	localparam seg_bank_t dark_bank = {5{8'hff}};

	seg_bank_t want_q [$]; // expected banks in load order
	int born_q [$]; // edge count at each load
	seg_bank_t last_display;
	int cycle;

	initial begin
		value_errors = 0;
		latency_errors = 0;
		other_errors = 0;
		updates_seen = 0;
		cycle = 0;
		last_display = dark_bank;
	end

	task automatic check_update();
		seg_bank_t want;
		int born;
		updates_seen++;
		if (want_q.size() == 0) begin
			other_errors++;
			$display("update pulse at cycle %0d with no load waiting for it", cycle);
		end else begin
			want = want_q.pop_front();
			born = born_q.pop_front();
			// load and updated are both seen one edge after they rise
			if (cycle - born != load_to_pulse) begin
				latency_errors++;
				$display("update for the load at cycle %0d came %0d cycles after it, not %0d",
					born, cycle - born, load_to_pulse);
			end
			if (display !== want) begin
				value_errors++;
				$display("error: display expected %h got %h", want, display);
			end
		end
		last_display = display;
	endtask

	// values read here are the ones from before the edge
	always @(posedge clk) begin
		cycle = cycle + 1;
		if (rst) begin
			want_q.delete();
			born_q.delete();
			last_display = dark_bank; // reset shows every display dark
		end else begin
			if (updated) begin
				check_update();
			end else if (display !== last_display) begin
				value_errors++;
				$display("error: display expected %h got %h while idle",
					last_display, display);
			end
			if (load) begin
				want_q.push_back(expect_bank);
				born_q.push_back(cycle);
			end
		end
	end

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock (
	output logic clk,
	output logic rst
);

	localparam int rst_cycles = 10;

	int edges;

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		edges = 0;
	end

	always #50 clk = ~clk; // 100 ns period

	always @(posedge clk) begin
		edges <= edges + 1;
		if (edges == rst_cycles - 1) begin
			rst <= 1'b0; // released on the tenth edge
		end
	end

endmodule

/* src/number_display.sv */
`timescale 1ns/100ps

module number_display (
	input logic clk,
	input logic rst,
	input logic load,
	input seg_pkg::value_t number,
	input logic hex_mode,
	output seg_pkg::seg_bank_t display,
	output logic updated
);
	import seg_pkg::*;

	logic cap_valid;
	logic cap_mode;
	value_t cap_value;
	logic ext_valid;
	logic ext_mode;
	digit_bank_t ext_digits;

	display_capture u_capture (
		.clk (clk),
		.rst (rst),
		.load (load),
		.number (number),
		.hex_mode (hex_mode),
		.valid (cap_valid),
		.mode (cap_mode),
		.value (cap_value)
	);

	digit_extract u_extract (
		.clk (clk),
		.rst (rst),
		.in_valid (cap_valid),
		.in_mode (cap_mode),
		.in_value (cap_value),
		.out_valid (ext_valid),
		.out_mode (ext_mode),
		.out_digits (ext_digits)
	);

	segment_encode u_encode (
		.clk (clk),
		.rst (rst),
		.valid (ext_valid),
		.hex_mode (ext_mode),
		.digits (ext_digits),
		.display (display),
		.updated (updated)
	);

endmodule

/* src/segment_encode.sv */
`timescale 1ns/100ps

module segment_encode (
	input logic clk,
	input logic rst,
	input logic valid,
	input logic hex_mode,
	input seg_pkg::digit_bank_t digits,
	output seg_pkg::seg_bank_t display,
	output logic updated
);
	import seg_pkg::*;

	logic zero_run; // this digit and all above are zero
	logic [num_digits-1:0] blank;
	seg_bank_t lit; // active high before inversion
	seg_bank_t next_display;

	always_comb begin
		zero_run = 1'b1;
		for (int k = num_digits - 1; k >= 0; k--) begin
			zero_run = zero_run && (digits[k] == '0);
			if (hex_mode) begin
				blank[k] = (k >= hex_digits); // top display unused
			end else begin
				blank[k] = zero_run && (k != 0); // ones digit always shown
			end
		end
	end

	always_comb begin
		for (int k = 0; k < num_digits; k++) begin
			lit[k] = '0;
			if (!blank[k]) begin
				lit[k][seg_dp-1:0] = seg_lut[digits[k]];
			end
			lit[k][seg_dp] = 1'b0; // point stays off
		end
	end

	assign next_display = ~lit;

	always_ff @(posedge clk) begin
		if (rst) begin
			display <= {num_digits{seg_blank}};
			updated <= 1'b0;
		end else begin
			updated <= valid;
			if (valid) begin
				display <= next_display;
			end
		end
	end

	a_pulse_width: assert property (@(posedge clk) disable iff (rst)
		updated && $past(updated) |-> $past(valid) && $past(valid, 2))
		else $error("updated held high without back to back samples");

endmodule

/* src/digit_extract.sv */
`timescale 1ns/100ps

module digit_extract (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic in_mode,
	input seg_pkg::value_t in_value,
	output logic out_valid,
	output logic out_mode,
	output seg_pkg::digit_bank_t out_digits
);
	import seg_pkg::*;

	stage_if link [0:num_digits] ();

	// head of the chain, no digits yet
	assign link[0].valid = in_valid;
	assign link[0].hex_mode = in_mode;
	assign link[0].rest = in_value;
	assign link[0].digits = '0;

	for (genvar k = 0; k < num_digits; k++) begin : g_stage
		radix_divide_stage #(
			.stage_index(k)
		) u_stage (
			.clk (clk),
			.rst (rst),
			.up (link[k].sink),
			.down (link[k+1].source)
		);
	end

	assign out_valid = link[num_digits].valid;
	assign out_mode = link[num_digits].hex_mode;
	assign out_digits = link[num_digits].digits;

	a_stage_delay: assert property (@(posedge clk) disable iff (rst)
		in_valid |-> ##num_digits out_valid)
		else $error("sample lost in the digit pipeline");

	// 16 bits never reach a sixth digit in either radix
	a_rest_empty: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> link[num_digits].rest == '0)
		else $error("value left over after the last stage");

endmodule

/* src/radix_divide_stage.sv */
`timescale 1ns/100ps

module radix_divide_stage #(
	parameter int stage_index = 0
) (
	input logic clk,
	input logic rst,
	stage_if.sink up,
	stage_if.source down
);
	import seg_pkg::*;

	logic [digit_w:0] part; // running remainder with the bit brought down
	logic [digit_w+1:0] diff;
	value_t dec_quot;
	digit_t dec_rem;
	value_t next_rest;
	digit_t next_digit;
	digit_bank_t next_digits;

	// restoring shift and subtract by ten, msb first
	always_comb begin
		part = '0;
		diff = '0;
		dec_quot = '0;
		for (int i = value_w - 1; i >= 0; i--) begin
			part = {part[digit_w-1:0], up.rest[i]}; // remainder stays below ten
			diff = {1'b0, part} - (digit_w + 2)'(radix_dec);
			if (!diff[digit_w+1]) begin // no borrow, keep the difference
				part = diff[digit_w:0];
				dec_quot[i] = 1'b1;
			end
		end
		dec_rem = part[digit_w-1:0];
	end

	// hex just peels the low nibble
	always_comb begin
		if (up.hex_mode) begin
			next_digit = up.rest[digit_w-1:0];
			next_rest = up.rest >> digit_w;
		end else begin
			next_digit = dec_rem;
			next_rest = dec_quot;
		end
		next_digits = up.digits;
		next_digits[stage_index] = next_digit;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			down.valid <= 1'b0;
		end else begin
			down.valid <= up.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (up.valid) begin
			down.hex_mode <= up.hex_mode;
			down.rest <= next_rest;
			down.digits <= next_digits;
		end
	end

	a_dec_digit: assert property (@(posedge clk) disable iff (rst)
		down.valid && !down.hex_mode |-> down.digits[stage_index] < digit_t'(radix_dec))
		else $error("decimal digit %0d out of range", stage_index);

	// quotient and remainder rebuild the value taken in a cycle earlier
	a_dec_split: assert property (@(posedge clk) disable iff (rst)
		up.valid && !up.hex_mode |=>
			32'(down.rest) * radix_dec + 32'(down.digits[stage_index])
				== 32'($past(up.rest)))
		else $error("divide by ten mismatch at stage %0d", stage_index);

endmodule

/* src/display_capture.sv */
`timescale 1ns/100ps

module display_capture (
	input logic clk,
	input logic rst,
	input logic load,
	input seg_pkg::value_t number,
	input logic hex_mode,
	output logic valid,
	output logic mode,
	output seg_pkg::value_t value
);

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= 1'b0;
		end else begin
			valid <= load; // one cycle per load
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			value <= number;
			mode <= hex_mode; // sampled together with the number
		end
	end

	// sample only moves on a load, so it sits still while valid is low
	a_hold_sample: assert property (@(posedge clk) disable iff (rst)
		!valid |-> $stable({mode, value}))
		else $error("capture changed without a load");

endmodule

/* src/stage_if.sv */
`timescale 1ns/100ps

interface stage_if;
	import seg_pkg::*;

	logic valid;
	logic hex_mode;
	value_t rest; // what is left to split into digits
	digit_bank_t digits; // positions filled so far

	modport source (
		output valid, hex_mode, rest, digits
	);

	modport sink (
		input valid, hex_mode, rest, digits
	);

endinterface

/* src/seg_pkg.sv */
package seg_pkg;

	localparam int value_w = 16;
	localparam int num_digits = 5; // displays and divide stages
	localparam int hex_digits = 4; // displays lit in hex mode
	localparam int digit_w = 4;
	localparam int seg_w = 8;
	localparam int seg_dp = 7; // decimal point bit
	localparam int radix_dec = 10;

	// load edge to updated pulse: capture, one per stage, output reg
	localparam int pipe_latency = 7;

	typedef logic [value_w-1:0] value_t;
	typedef logic [digit_w-1:0] digit_t;
	typedef digit_t [num_digits-1:0] digit_bank_t; // [0] is the ones digit
	typedef logic [seg_w-1:0] seg_t;
	typedef seg_t [num_digits-1:0] seg_bank_t;

	// active high, bits {m, lt, lb, b, rb, rt, t}
	localparam logic [seg_dp-1:0] seg_lut [0:15] = '{
		7'b0111111, // 0
		7'b0000110, // 1
		7'b1011011, // 2
		7'b1001111, // 3
		7'b1100110, // 4
		7'b1101101, // 5
		7'b1111101, // 6
		7'b0000111, // 7
		7'b1111111, // 8
		7'b1100111, // 9
		7'b1110111, // a
		7'b1111100, // b
		7'b0111001, // c
		7'b1011110, // d
		7'b1111001, // e
		7'b1110001  // f
	};

	localparam seg_t seg_blank = '1; // every segment dark, pads are active low

endpackage
